/* source/dbgnoc_pkg.sv */
// Debug-NoC flit format definitions, imported by any block that sends or receives NoC flits

package dbgnoc_pkg;

   localparam int unsigned FLIT_DATA_WIDTH = 16;  // Payload bits per flit
   localparam int unsigned FLIT_TYPE_WIDTH = 2;   // Type bits per flit

   // Flit type codes, SINGLE marks both header and last flit
   typedef enum logic [FLIT_TYPE_WIDTH-1:0] {
      PAYLOAD = 2'd0,  // Body flit
      HEADER  = 2'd1,  // First flit of a multi-flit packet
      LAST    = 2'd2,  // Closes a multi-flit packet
      SINGLE  = 2'd3   // Whole packet in one flit
   } flit_type_t;

   // Type sits above the data, 18 bits total
   typedef struct packed {
      flit_type_t                 ftype;  // Flit type code
      logic [FLIT_DATA_WIDTH-1:0] data;   // Flit payload
   } flit_t;

endpackage

/* source/dbg_mem_pkg.sv */
// Debug memory command definitions: widths, opcodes, status codes and header field layout

package dbg_mem_pkg;

   localparam int unsigned ADDR_WIDTH = 16;  // Word address, fits one flit
   localparam int unsigned DATA_WIDTH = 32;  // Memory word, two flits high half first

   typedef logic [3:0] opcode_t;  // Command opcode
   typedef logic [3:0] status_t;  // Response status
   typedef logic [7:0] tag_t;     // Echoed to response

   localparam opcode_t OP_READ  = 4'd1;  // Read one word
   localparam opcode_t OP_WRITE = 4'd2;  // Write one word
                                         // All other codes unknown

   localparam status_t ST_OK     = 4'd0;  // Access done
   localparam status_t ST_FORMAT = 4'd1;  // Bad length or opcode
   localparam status_t ST_RANGE  = 4'd2;  // Address outside window

   // Header flit fields
   localparam int unsigned HDR_OP_HI  = 15;  // Opcode field
   localparam int unsigned HDR_OP_LO  = 12;
   localparam int unsigned HDR_ST_HI  = 11;  // Status, response only
   localparam int unsigned HDR_ST_LO  = 8;
   localparam int unsigned HDR_TAG_HI = 7;   // Tag field
   localparam int unsigned HDR_TAG_LO = 0;

   // Expected packet lengths in flits
   localparam int unsigned READ_FLITS  = 2;  // Header, address
   localparam int unsigned WRITE_FLITS = 4;  // Header, address, data high, data low

endpackage

/* source/dbg_cmd_if.sv */
// Command handshake from the packet decoder to the memory execute stage; use its modports

interface dbg_cmd_if;
   import dbg_mem_pkg::*;

   logic                  cmd_valid;   // Command held by decode
   opcode_t               opcode;      // From header
   tag_t                  tag;         // From header
   logic [ADDR_WIDTH-1:0] addr;        // Word address
   logic [DATA_WIDTH-1:0] wdata;       // Write data
   logic                  bad_format;  // Length or opcode error
   logic                  cmd_take;    // Execute accepts command

   modport decode (
      output cmd_valid, opcode, tag, addr, wdata, bad_format,
      input  cmd_take
   );

   modport execute (
      input  cmd_valid, opcode, tag, addr, wdata, bad_format,
      output cmd_take
   );

endinterface

/* source/dbg_resp_if.sv */
// Result handoff from the memory execute stage to the response builder; use its modports

interface dbg_resp_if;
   import dbg_mem_pkg::*;

   logic                  resp_valid;  // One-cycle result pulse
   opcode_t               opcode;      // Echoed opcode
   tag_t                  tag;         // Echoed tag
   status_t               status;      // Access outcome
   logic [DATA_WIDTH-1:0] rdata;       // Valid only for good read
   logic                  resp_busy;   // Response still on the wire

   modport execute (
      output resp_valid, opcode, tag, status, rdata,
      input  resp_busy
   );

   modport result (
      input  resp_valid, opcode, tag, status, rdata,
      output resp_busy
   );

endinterface

/* source/dbg_packet_decode.sv */
// Gathers incoming Debug-NoC flits into one memory command and flags malformed packets

module dbg_packet_decode (
   input  logic              clk,
   input  logic              reset_i,
   input  dbgnoc_pkg::flit_t in_flit_i,
   input  logic              in_valid_i,
   output logic              in_ready_o,
   dbg_cmd_if.decode         cmd
);
   import dbgnoc_pkg::*;
   import dbg_mem_pkg::*;

   logic       in_pkt_q;    // Inside a packet, header seen
   logic [2:0] flit_cnt_q;  // Flits counted so far, saturates at 5
   logic [2:0] cnt_next;    // Count including current flit
   logic       flit_acc;    // Handshake on input
   logic       is_head;     // HEADER or SINGLE
   logic       is_last;     // LAST or SINGLE
   logic       pkt_flit;    // Accepted flit belongs to a packet
   logic       pkt_end;     // Accepted flit closes the packet
   opcode_t    pkt_op;      // Opcode of current packet
   logic       len_ok;      // Length matches opcode

   assign in_ready_o = !cmd.cmd_valid;  // Stall only while command is pending
   assign flit_acc   = in_valid_i && in_ready_o;
   assign is_head    = (in_flit_i.ftype == HEADER) || (in_flit_i.ftype == SINGLE);
   assign is_last    = (in_flit_i.ftype == LAST) || (in_flit_i.ftype == SINGLE);
   assign pkt_flit   = flit_acc && (in_pkt_q || is_head);  // Idle non-headers dropped
   assign pkt_end    = pkt_flit && is_last;

   always_comb begin
      // SINGLE header carries its opcode in the same cycle
      pkt_op = in_pkt_q ? cmd.opcode : in_flit_i.data[HDR_OP_HI:HDR_OP_LO];
      if (!in_pkt_q) begin
         cnt_next = 3'd1;              // Header is flit 1
      end else if (flit_cnt_q == 3'd5) begin
         cnt_next = 3'd5;              // Saturate, long packets stay bad
      end else begin
         cnt_next = flit_cnt_q + 3'd1;
      end
      case (pkt_op)
         OP_READ:  len_ok = (cnt_next == 3'(READ_FLITS));
         OP_WRITE: len_ok = (cnt_next == 3'(WRITE_FLITS));
         default:  len_ok = 1'b0;      // Unknown opcode is a format error
      endcase
   end

   // Packet tracking and command handshake
   always_ff @(posedge clk) begin
      if (reset_i) begin
         in_pkt_q      <= 1'b0;
         flit_cnt_q    <= '0;
         cmd.cmd_valid <= 1'b0;
      end else begin
         if (cmd.cmd_take) begin
            cmd.cmd_valid <= 1'b0;    // Drop the cycle after take
         end
         if (pkt_flit) begin
            flit_cnt_q <= cnt_next;
            in_pkt_q   <= !is_last;    // Stay open until LAST
         end
         if (pkt_end) begin
            cmd.cmd_valid <= 1'b1;    // Rises one cycle after last flit
         end
      end
   end

   // Command fields, only written while no command is held
   always_ff @(posedge clk) begin
      if (flit_acc && !in_pkt_q && is_head) begin
         cmd.opcode <= in_flit_i.data[HDR_OP_HI:HDR_OP_LO];
         cmd.tag    <= in_flit_i.data[HDR_TAG_HI:HDR_TAG_LO];
      end
      if (flit_acc && in_pkt_q) begin
         case (flit_cnt_q)
            3'd1:    cmd.addr <= in_flit_i.data;                               // Flit 2
            3'd2:    cmd.wdata[DATA_WIDTH-1:FLIT_DATA_WIDTH] <= in_flit_i.data; // Flit 3
            3'd3:    cmd.wdata[FLIT_DATA_WIDTH-1:0] <= in_flit_i.data;          // Flit 4
            default: ;                                                         // Extra flits
         endcase
      end
      if (pkt_end) begin
         cmd.bad_format <= !len_ok;
      end
   end

endmodule

/* source/dbg_mem_execute.sv */
// Debug memory window with range-checked single-word reads and writes, one command at a time

module dbg_mem_execute #(
   parameter logic [dbg_mem_pkg::ADDR_WIDTH-1:0] MEM_MIN_ADDR = 16'h0100,  // First word
   parameter logic [dbg_mem_pkg::ADDR_WIDTH-1:0] MEM_MAX_ADDR = 16'h013F   // Last word, inclusive
) (
   input  logic       clk,
   input  logic       reset_i,
   dbg_cmd_if.execute cmd,
   dbg_resp_if.execute resp
);
   import dbg_mem_pkg::*;

   localparam int unsigned MEM_DEPTH = int'(MEM_MAX_ADDR) - int'(MEM_MIN_ADDR) + 1;
   localparam int unsigned MEM_AW    = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

   logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];  // Window storage, no init

   logic                  take;       // Command accepted this cycle
   logic                  in_window;  // Address inside window
   logic [ADDR_WIDTH-1:0] offset;     // Address relative to window base
   logic [MEM_AW-1:0]     mem_idx;    // Array index
   status_t               status_d;   // Outcome of this command
   logic                  access_ok;  // Memory may be touched

   assign take      = cmd.cmd_valid && !resp.resp_busy;  // Wait until result is free
   assign cmd.cmd_take = take;
   assign in_window = (cmd.addr >= MEM_MIN_ADDR) && (cmd.addr <= MEM_MAX_ADDR);
   assign offset    = cmd.addr - MEM_MIN_ADDR;
   assign mem_idx   = offset[MEM_AW-1:0];

   always_comb begin
      if (cmd.bad_format) begin
         status_d = ST_FORMAT;  // Format wins over range
      end else if (!in_window) begin
         status_d = ST_RANGE;
      end else begin
         status_d = ST_OK;
      end
   end

   assign access_ok = take && (status_d == ST_OK);

   // Memory access and result payload
   always_ff @(posedge clk) begin
      if (access_ok && (cmd.opcode == OP_WRITE)) begin
         mem[mem_idx] <= cmd.wdata;
      end
      if (access_ok && (cmd.opcode == OP_READ)) begin
         resp.rdata <= mem[mem_idx];  // Registered read
      end
      if (take) begin
         resp.opcode <= cmd.opcode;
         resp.tag    <= cmd.tag;
         resp.status <= status_d;
      end
   end

   // Result strobe, one cycle after take
   always_ff @(posedge clk) begin
      if (reset_i) begin
         resp.resp_valid <= 1'b0;
      end else begin
         resp.resp_valid <= take;
      end
   end

endmodule

/* source/dbg_response_build.sv */
// Serializes an executed result into response flits on the outgoing Debug-NoC port

module dbg_response_build (
   input  logic              clk,
   input  logic              reset_i,
   dbg_resp_if.result        resp,
   output dbgnoc_pkg::flit_t out_flit_o,
   output logic              out_valid_o,
   input  logic              out_ready_i
);
   import dbgnoc_pkg::*;
   import dbg_mem_pkg::*;

   logic [1:0]                 cnt_q;   // Flits still to send
   logic                       long_q;  // Read response with data
   logic [FLIT_DATA_WIDTH-1:0] hdr_q;   // Response header data
   logic [DATA_WIDTH-1:0]      rdata_q; // Read word
   logic                       flit_acc;

   assign out_valid_o    = (cnt_q != 2'd0);
   assign resp.resp_busy = (cnt_q != 2'd0);  // Holds execute until last flit leaves
   assign flit_acc       = out_valid_o && out_ready_i;

   // Flit select from remaining count
   always_comb begin
      out_flit_o.ftype = SINGLE;
      out_flit_o.data  = hdr_q;
      if (long_q) begin
         case (cnt_q)
            2'd3: begin
               out_flit_o.ftype = HEADER;
               out_flit_o.data  = hdr_q;
            end
            2'd2: begin
               out_flit_o.ftype = PAYLOAD;  // High half first
               out_flit_o.data  = rdata_q[DATA_WIDTH-1:FLIT_DATA_WIDTH];
            end
            default: begin
               out_flit_o.ftype = LAST;
               out_flit_o.data  = rdata_q[FLIT_DATA_WIDTH-1:0];
            end
         endcase
      end
   end

   // Response payload captured on the result pulse
   always_ff @(posedge clk) begin
      if (resp.resp_valid) begin
         hdr_q[HDR_OP_HI:HDR_OP_LO]   <= resp.opcode;
         hdr_q[HDR_ST_HI:HDR_ST_LO]   <= resp.status;
         hdr_q[HDR_TAG_HI:HDR_TAG_LO] <= resp.tag;
         rdata_q <= resp.rdata;
         long_q  <= (resp.opcode == OP_READ) && (resp.status == ST_OK);
      end
   end

   // Flit counter
   always_ff @(posedge clk) begin
      if (reset_i) begin
         cnt_q <= 2'd0;
      end else if (resp.resp_valid) begin
         if ((resp.opcode == OP_READ) && (resp.status == ST_OK)) begin
            cnt_q <= 2'd3;  // Header, data high, data low
         end else begin
            cnt_q <= 2'd1;  // Lone SINGLE header
         end
      end else if (flit_acc) begin
         cnt_q <= cnt_q - 2'd1;
      end
   end

endmodule

/* source/debug_coprocessor.sv */
// Debug co-processor top: NoC command decode, memory execute and response build, plain NoC ports

module debug_coprocessor #(
   parameter logic [dbg_mem_pkg::ADDR_WIDTH-1:0] MEM_MIN_ADDR = 16'h0100,  // Window start
   parameter logic [dbg_mem_pkg::ADDR_WIDTH-1:0] MEM_MAX_ADDR = 16'h013F   // Window end
) (
   input  logic              clk,
   input  logic              reset_i,

   // Incoming Debug-NoC
   input  dbgnoc_pkg::flit_t dbgnoc_in_flit_i,
   input  logic              dbgnoc_in_valid_i,
   output logic              dbgnoc_in_ready_o,

   // Outgoing Debug-NoC
   output dbgnoc_pkg::flit_t dbgnoc_out_flit_o,
   output logic              dbgnoc_out_valid_o,
   input  logic              dbgnoc_out_ready_i
);

   dbg_cmd_if  cmd_if ();   // Decode to execute
   dbg_resp_if resp_if ();  // Execute to result

   // Flits in, command out
   dbg_packet_decode dbg_packet_decode_inst (
      .clk        (clk),
      .reset_i    (reset_i),
      .in_flit_i  (dbgnoc_in_flit_i),
      .in_valid_i (dbgnoc_in_valid_i),
      .in_ready_o (dbgnoc_in_ready_o),
      .cmd        (cmd_if.decode)
   );

   // Memory window
   dbg_mem_execute #(
      .MEM_MIN_ADDR (MEM_MIN_ADDR),
      .MEM_MAX_ADDR (MEM_MAX_ADDR)
   ) dbg_mem_execute_inst (
      .clk     (clk),
      .reset_i (reset_i),
      .cmd     (cmd_if.execute),
      .resp    (resp_if.execute)
   );

   // Result in, flits out
   dbg_response_build dbg_response_build_inst (
      .clk         (clk),
      .reset_i     (reset_i),
      .resp        (resp_if.result),
      .out_flit_o  (dbgnoc_out_flit_o),
      .out_valid_o (dbgnoc_out_valid_o),
      .out_ready_i (dbgnoc_out_ready_i)
   );

endmodule

/* test/debug_coprocessor_assert.sv */
// Output-port protocol checks for the debug co-processor, attached to the top level by bind

module debug_coprocessor_assert (
   input logic              clk,
   input logic              reset_i,
   input dbgnoc_pkg::flit_t out_flit_i,
   input logic              out_valid_i,
   input logic              out_ready_i
);
   import dbgnoc_pkg::*;

   logic in_pkt_q;  // Between HEADER and LAST

   always_ff @(posedge clk) begin
      if (reset_i) begin
         in_pkt_q <= 1'b0;
      end else if (out_valid_i && out_ready_i) begin
         in_pkt_q <= (out_flit_i.ftype == HEADER) || (in_pkt_q && (out_flit_i.ftype == PAYLOAD));
      end
   end

   hold_while_stalled: assert property (@(posedge clk) disable iff (reset_i)
      (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_flit_i)))
      else $error("Output flit changed or dropped while stalled");

   idle_after_reset: assert property (@(posedge clk) reset_i |=> !out_valid_i)
      else $error("Output valid high right after reset");

   type_order: assert property (@(posedge clk) disable iff (reset_i)
      (out_valid_i && out_ready_i) |->
         (in_pkt_q ? ((out_flit_i.ftype == PAYLOAD) || (out_flit_i.ftype == LAST))
                   : ((out_flit_i.ftype == HEADER) || (out_flit_i.ftype == SINGLE))))
      else $error("Output flit type out of packet order");

endmodule

bind debug_coprocessor debug_coprocessor_assert debug_coprocessor_assert_inst (
   .clk         (clk),
   .reset_i     (reset_i),
   .out_flit_i  (dbgnoc_out_flit_o),
   .out_valid_i (dbgnoc_out_valid_o),
   .out_ready_i (dbgnoc_out_ready_i)
);

/* test/debug_coprocessor_tb.sv */
// Table-driven testbench that drives the debug co-processor top level when compiled from sim.f

module debug_coprocessor_tb;
   import dbgnoc_pkg::*;
   import dbg_mem_pkg::*;

   localparam logic [15:0] WIN_MIN = 16'h0100;  // Window bounds under test
   localparam logic [15:0] WIN_MAX = 16'h013F;
   localparam int MAX_TESTS = 20;
   localparam int MAX_FLITS = 6;   // Longest command incl. stray flits

   logic  clk;
   logic  reset_i;
   flit_t dbgnoc_in_flit_i;
   logic  dbgnoc_in_valid_i;
   logic  dbgnoc_in_ready_o;
   flit_t dbgnoc_out_flit_o;
   logic  dbgnoc_out_valid_o;
   logic  dbgnoc_out_ready_i;

   string       test_name [MAX_TESTS];             // Stimulus table
   flit_t       cmd_flits [MAX_TESTS][MAX_FLITS];  // Command flits per test
   flit_t       exp_flits [MAX_TESTS][3];          // Expected response flits
   int          cmd_count [MAX_TESTS];
   int          exp_count [MAX_TESTS];
   int          num_tests;
   int          total_flits;   // Sizes the watchdog
   logic        table_done;
   tag_t        cur_tag;       // Tag of the test being built
   int          errors;
   int          bad_tests;
   logic [31:0] lcg_state;     // Back-pressure generator
   flit_t       got_flit;
   logic        match;
   logic        test_ok;

   debug_coprocessor #(
      .MEM_MIN_ADDR (WIN_MIN),
      .MEM_MAX_ADDR (WIN_MAX)
   ) debug_coprocessor_inst (
      .clk                (clk),
      .reset_i            (reset_i),
      .dbgnoc_in_flit_i   (dbgnoc_in_flit_i),
      .dbgnoc_in_valid_i  (dbgnoc_in_valid_i),
      .dbgnoc_in_ready_o  (dbgnoc_in_ready_o),
      .dbgnoc_out_flit_o  (dbgnoc_out_flit_o),
      .dbgnoc_out_valid_o (dbgnoc_out_valid_o),
      .dbgnoc_out_ready_i (dbgnoc_out_ready_i)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;  // 10 unit period

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic new_test(input string name);
      test_name[num_tests] = name;
      cmd_count[num_tests] = 0;
      exp_count[num_tests] = 0;
      cur_tag = 8'h40 + 8'(num_tests);  // Unique tag per test
      num_tests++;
   endtask

   task automatic push_cmd(input flit_type_t t, input logic [15:0] d);
      int i;
      i = num_tests - 1;
      cmd_flits[i][cmd_count[i]].ftype = t;
      cmd_flits[i][cmd_count[i]].data  = d;
      cmd_count[i]++;
      total_flits++;
   endtask

   task automatic push_exp(input flit_type_t t, input logic [15:0] d);
      int i;
      i = num_tests - 1;
      exp_flits[i][exp_count[i]].ftype = t;
      exp_flits[i][exp_count[i]].data  = d;
      exp_count[i]++;
      total_flits++;
   endtask

   // Command header with the ignored bits 11:8 set nonzero
   function automatic logic [15:0] cmd_header(input opcode_t op);
      return {op, 4'hA, cur_tag};
   endfunction

   task automatic read_cmd(input logic [15:0] addr);
      push_cmd(HEADER, cmd_header(OP_READ));
      push_cmd(LAST, addr);
   endtask

   task automatic write_cmd(input logic [15:0] addr, input logic [31:0] data);
      push_cmd(HEADER, cmd_header(OP_WRITE));
      push_cmd(PAYLOAD, addr);
      push_cmd(PAYLOAD, data[31:16]);  // High half first
      push_cmd(LAST, data[15:0]);
   endtask

   task automatic expect_short(input opcode_t op, input status_t st);
      push_exp(SINGLE, {op, st, cur_tag});
   endtask

   task automatic expect_read(input logic [31:0] data);
      push_exp(HEADER, {OP_READ, ST_OK, cur_tag});
      push_exp(PAYLOAD, data[31:16]);
      push_exp(LAST, data[15:0]);
   endtask

   task automatic build_table;
      num_tests   = 0;
      total_flits = 0;
      new_test("wr_mid");
      write_cmd(16'h0105, 32'hCAFE_1234);
      expect_short(OP_WRITE, ST_OK);
      new_test("rd_mid");
      read_cmd(16'h0105);
      expect_read(32'hCAFE_1234);
      new_test("wr_low_edge");
      write_cmd(WIN_MIN, 32'h1111_2222);
      expect_short(OP_WRITE, ST_OK);
      new_test("wr_high_edge");
      write_cmd(WIN_MAX, 32'h3333_4444);
      expect_short(OP_WRITE, ST_OK);
      new_test("rd_below");
      read_cmd(WIN_MIN - 16'd1);
      expect_short(OP_READ, ST_RANGE);
      new_test("wr_below");
      write_cmd(WIN_MIN - 16'd1, 32'hBAD0_0001);
      expect_short(OP_WRITE, ST_RANGE);
      new_test("rd_above");
      read_cmd(WIN_MAX + 16'd1);
      expect_short(OP_READ, ST_RANGE);
      new_test("wr_above");
      write_cmd(WIN_MAX + 16'd1, 32'hBAD0_0002);
      expect_short(OP_WRITE, ST_RANGE);
      new_test("rd_after_range");
      read_cmd(WIN_MIN);                 // Slot a wrapped index would hit
      expect_read(32'h1111_2222);
      new_test("rd_extra_flit");
      push_cmd(HEADER, cmd_header(OP_READ));
      push_cmd(PAYLOAD, 16'h0105);
      push_cmd(LAST, 16'h0000);          // One flit too many
      expect_short(OP_READ, ST_FORMAT);
      new_test("wr_short");
      push_cmd(HEADER, cmd_header(OP_WRITE));
      push_cmd(PAYLOAD, 16'h0105);
      push_cmd(LAST, 16'hDEAD);          // Low half missing
      expect_short(OP_WRITE, ST_FORMAT);
      new_test("op_unknown");
      push_cmd(HEADER, cmd_header(4'h3));
      push_cmd(LAST, 16'h0105);
      expect_short(4'h3, ST_FORMAT);
      new_test("rd_after_format");
      read_cmd(16'h0105);
      expect_read(32'hCAFE_1234);
      new_test("stray_then_rd");
      push_cmd(PAYLOAD, 16'hAAAA);       // Dropped while idle
      push_cmd(LAST, 16'h5555);
      read_cmd(WIN_MAX);
      expect_read(32'h3333_4444);
      new_test("rd_low_edge");
      read_cmd(WIN_MIN);
      expect_read(32'h1111_2222);
   endtask

   task automatic compare_value(input string name, input logic [17:0] expected,
                                input logic [17:0] actual, output logic ok);
      ok = (actual === expected);
      if (!ok) begin
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // Entered and left one unit after a rising edge
   task automatic send_flit(input flit_t f);
      dbgnoc_in_flit_i  = f;
      dbgnoc_in_valid_i = 1'b1;
      @(negedge clk);
      while (!dbgnoc_in_ready_o) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic take_out_flit(output flit_t f);
      @(negedge clk);
      while (!(dbgnoc_out_valid_o && dbgnoc_out_ready_i)) begin
         @(negedge clk);
      end
      f = dbgnoc_out_flit_o;  // Accepted on the coming edge
      @(posedge clk);
   endtask

   // Random back-pressure with about three ready cycles in four
   initial begin
      dbgnoc_out_ready_i = 1'b0;
      lcg_state = 32'd6;
      forever begin
         @(posedge clk);
         #1;
         lcg_state = lcg_next(lcg_state);
         dbgnoc_out_ready_i = (lcg_state[17:16] != 2'b00);
      end
   end

   initial begin
      wait (table_done === 1'b1);
      repeat (total_flits * 40) begin
         @(posedge clk);
      end
      $display("Run timed out after %0d cycles, responses still missing", total_flits * 40);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      reset_i           = 1'b1;
      dbgnoc_in_valid_i = 1'b0;
      dbgnoc_in_flit_i  = '0;
      table_done        = 1'b0;
      errors            = 0;
      bad_tests         = 0;
      build_table();
      table_done = 1'b1;
      repeat (3) begin
         @(posedge clk);
      end
      #1;
      reset_i = 1'b0;
      fork
         begin : driver
            for (int t = 0; t < num_tests; t++) begin
               for (int f = 0; f < cmd_count[t]; f++) begin
                  send_flit(cmd_flits[t][f]);  // Back to back
               end
            end
            dbgnoc_in_valid_i = 1'b0;
         end
         begin : monitor
            for (int t = 0; t < num_tests; t++) begin
               test_ok = 1'b1;
               for (int f = 0; f < exp_count[t]; f++) begin
                  take_out_flit(got_flit);
                  compare_value(test_name[t], exp_flits[t][f], got_flit, match);
                  test_ok = test_ok && match;
               end
               if (!test_ok) begin
                  bad_tests++;
               end
               $display("test %0d %s: %s", t, test_name[t], test_ok ? "ok" : "mismatch");
            end
         end
      join
      // Nothing may follow the last response
      repeat (8) begin
         @(negedge clk);
         if (dbgnoc_out_valid_o) begin
            $display("Unexpected response flit after the last test");
            errors++;
         end
      end
      $display("%0d tests, %0d with mismatches, %0d errors", num_tests, bad_tests, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* sim.f */
source/dbgnoc_pkg.sv
source/dbg_mem_pkg.sv
source/dbg_cmd_if.sv
source/dbg_resp_if.sv
source/dbg_packet_decode.sv
source/dbg_mem_execute.sv
source/dbg_response_build.sv
source/debug_coprocessor.sv
test/debug_coprocessor_assert.sv
test/debug_coprocessor_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the debug co-processor simulation with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f sim.f --top-module debug_coprocessor_tb \
   -o sim_tb \
   && ./obj_dir/sim_tb | tee sim.log \
   || { echo "Verilator build or run failed"; exit 1; }

grep -qF "*** TEST PASSED ***" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }
